// File: build.f
saturn_bus_pkg.sv
bus_ctrl_if.sv
bus_cmd_ctrl.sv
bus_pointer_regs.sv
nibble_memory.sv
saturn_bus_slave_top.sv
tb_saturn_bus_slave.sv

// File: bus_cmd_ctrl.sv
// Bus command controller, latches commands, counts address nibbles and issues strobes
`timescale 1ns/1ps
`default_nettype none

module bus_cmd_ctrl (
    input  wire logic                              i_clk,
    input  wire logic                              i_reset,
    input  wire logic                              i_bus_clk_en,
    input  wire logic                              i_bus_is_data,
    input  wire logic [saturn_bus_pkg::NIBBLE_W-1:0] i_bus_nibble_in,
    bus_ctrl_if.ctrl                               o_ctrl
);
    import saturn_bus_pkg::*;

    bus_cmd_t   cmd_q;         // Last latched command
    bus_cmd_t   cmd_in;
    logic [2:0] pos_q;         // Address nibble counter
    logic       cmd_stb;
    logic       data_stb;
    logic       reset_cmd;
    logic       loading;
    logic       last_pos;

    assign cmd_stb   = i_bus_clk_en && !i_bus_is_data;
    assign data_stb  = i_bus_clk_en && i_bus_is_data;
    assign cmd_in    = bus_cmd_t'(i_bus_nibble_in);
    assign reset_cmd = cmd_stb && (cmd_in == CMD_RESET);
    assign loading   = (cmd_q == CMD_LOAD_PC) || (cmd_q == CMD_LOAD_DP);
    assign last_pos  = (pos_q == 3'(PTR_NIBBLES - 1));

    assign o_ctrl.load_pos = pos_q;
    assign o_ctrl.sel_dp   = (cmd_q == CMD_DP_READ) || (cmd_q == CMD_DP_WRITE) ||
                             (cmd_q == CMD_LOAD_DP);

    // Decode the latched command into this cycle's strobes
    always_comb begin
        o_ctrl.load_pc = 1'b0;
        o_ctrl.load_dp = 1'b0;
        o_ctrl.inc_pc  = 1'b0;
        o_ctrl.inc_dp  = 1'b0;
        o_ctrl.rd_en   = 1'b0;
        o_ctrl.wr_en   = 1'b0;
        o_ctrl.nibble  = i_bus_nibble_in;
        if (reset_cmd) begin
            // Both loads together clear the pointers
            o_ctrl.load_pc = 1'b1;
            o_ctrl.load_dp = 1'b1;
            o_ctrl.nibble  = '0;
        end else if (data_stb) begin
            case (cmd_q)
                CMD_PC_READ: begin
                    o_ctrl.rd_en  = 1'b1;
                    o_ctrl.inc_pc = 1'b1;
                end
                CMD_DP_READ: begin
                    o_ctrl.rd_en  = 1'b1;
                    o_ctrl.inc_dp = 1'b1;
                end
                CMD_PC_WRITE: begin
                    o_ctrl.wr_en  = 1'b1;
                    o_ctrl.inc_pc = 1'b1;
                end
                CMD_DP_WRITE: begin
                    o_ctrl.wr_en  = 1'b1;
                    o_ctrl.inc_dp = 1'b1;
                end
                CMD_LOAD_PC: o_ctrl.load_pc = 1'b1;
                CMD_LOAD_DP: o_ctrl.load_dp = 1'b1;
                default: ;                          // Other commands are ignored
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cmd_q <= CMD_PC_READ;
            pos_q <= '0;
        end else if (cmd_stb) begin
            if (reset_cmd) begin
                cmd_q <= CMD_PC_READ;               // RESET also clears the command
            end else begin
                cmd_q <= cmd_in;
            end
            if ((cmd_in == CMD_LOAD_PC) || (cmd_in == CMD_LOAD_DP)) begin
                pos_q <= '0;
            end
        end else if (data_stb && loading) begin
            if (last_pos) begin
                pos_q <= '0;
                // Fifth nibble switches to the matching read
                cmd_q <= (cmd_q == CMD_LOAD_PC) ? CMD_PC_READ : CMD_DP_READ;
            end else begin
                pos_q <= pos_q + 3'd1;
            end
        end
    end

    a_pos_range: assert property (
        @(posedge i_clk) disable iff (i_reset)
        pos_q <= 3'(PTR_NIBBLES - 1)
    );

endmodule

`default_nettype wire

// File: bus_ctrl_if.sv
// Strobes and data from the bus command controller to the pointer and memory blocks
`timescale 1ns/1ps
`default_nettype none

interface bus_ctrl_if;
    import saturn_bus_pkg::*;

    logic                load_pc;     // Load a nibble into PC
    logic                load_dp;     // Load a nibble into DP
    logic [2:0]          load_pos;    // Nibble slot being loaded
    logic                inc_pc;
    logic                inc_dp;
    logic                sel_dp;      // DP addresses the memory
    logic                rd_en;
    logic                wr_en;
    logic [NIBBLE_W-1:0] nibble;      // Data nibble from the bus

    modport ctrl (
        output load_pc, load_dp, load_pos,
        output inc_pc, inc_dp, sel_dp,
        output rd_en, wr_en, nibble
    );

    modport ptr (
        input load_pc, load_dp, load_pos,
        input inc_pc, inc_dp, sel_dp,
        input nibble
    );

    modport mem (
        input rd_en, wr_en, nibble
    );

endinterface

`default_nettype wire

// File: bus_pointer_regs.sv
// PC and DP pointer registers with nibble load, increment and address select
`timescale 1ns/1ps
`default_nettype none

module bus_pointer_regs (
    input  wire logic             i_clk,
    input  wire logic             i_reset,
    bus_ctrl_if.ptr               i_ctrl,
    output saturn_bus_pkg::ptr_t  o_addr
);
    import saturn_bus_pkg::*;

    ptr_t pc_q;
    ptr_t dp_q;
    logic clear;

    // Both load strobes at once is the RESET command
    assign clear  = i_ctrl.load_pc && i_ctrl.load_dp;
    assign o_addr = i_ctrl.sel_dp ? dp_q : pc_q;

    always_ff @(posedge i_clk) begin
        if (i_reset || clear) begin
            pc_q <= '0;
        end else if (i_ctrl.load_pc) begin
            pc_q[i_ctrl.load_pos*NIBBLE_W +: NIBBLE_W] <= i_ctrl.nibble;  // LSN first
        end else if (i_ctrl.inc_pc) begin
            pc_q <= pc_q + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset || clear) begin
            dp_q <= '0;
        end else if (i_ctrl.load_dp) begin
            dp_q[i_ctrl.load_pos*NIBBLE_W +: NIBBLE_W] <= i_ctrl.nibble;
        end else if (i_ctrl.inc_dp) begin
            dp_q <= dp_q + 1'b1;
        end
    end

    a_no_load_inc: assert property (
        @(posedge i_clk) disable iff (i_reset)
        !(i_ctrl.load_pc && i_ctrl.inc_pc) && !(i_ctrl.load_dp && i_ctrl.inc_dp)
    );

endmodule

`default_nettype wire

// File: nibble_memory.sv
// Windowed nibble memory with a ROM half and a RAM half, registered bus read
`timescale 1ns/1ps
`default_nettype none

module nibble_memory (
    input  wire logic                                i_clk,
    input  wire logic                                i_reset,
    bus_ctrl_if.mem                                  i_ctrl,
    input  wire saturn_bus_pkg::ptr_t                i_addr,
    output logic [saturn_bus_pkg::NIBBLE_W-1:0]      o_bus_nibble_out
);
    import saturn_bus_pkg::*;

    logic [NIBBLE_W-1:0]          rom [ROM_DEPTH];
    logic [NIBBLE_W-1:0]          ram [RAM_DEPTH];
    logic [WIN_BITS-1:0]          win;       // Higher address bits alias
    logic                         ram_sel;
    logic [$clog2(RAM_DEPTH)-1:0] idx;

    initial begin
        $readmemh(ROM_FILE, rom);
    end

    assign win     = i_addr[WIN_BITS-1:0];
    assign ram_sel = win[WIN_BITS-1];
    assign idx     = win[$clog2(RAM_DEPTH)-1:0];

    // Read uses the pointer value from before its increment
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_bus_nibble_out <= '0;
        end else if (i_ctrl.rd_en) begin
            o_bus_nibble_out <= ram_sel ? ram[idx] : rom[idx];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_ctrl.wr_en && ram_sel) begin
            ram[idx] <= i_ctrl.nibble;           // ROM half drops writes
        end
    end

    a_rd_wr_excl: assert property (
        @(posedge i_clk) disable iff (i_reset)
        !(i_ctrl.rd_en && i_ctrl.wr_en)
    );

endmodule

`default_nettype wire

// File: rom.hex
// One column, one hex ROM nibble per line, window addresses 0 to 31 in order
3
8
d
2
7
c
1
6
b
0
5
a
f
4
9
e
2
9
c
3
6
d
0
7
a
1
4
b
e
5
8
f

// File: saturn_bus_pkg.sv
// Saturn bus slave package with command codes, bus widths and memory sizes
`default_nettype none

package saturn_bus_pkg;

    // Bus and pointer geometry
    localparam int NIBBLE_W    = 4;           // One bus transfer
    localparam int PTR_W       = 20;          // Saturn address width
    localparam int PTR_NIBBLES = PTR_W / NIBBLE_W;  // Nibbles per pointer load

    // Memory window, low address bits only
    localparam int WIN_BITS  = 6;
    localparam int ROM_DEPTH = 32;            // Window bit 5 low
    localparam int RAM_DEPTH = 32;            // Window bit 5 high

    localparam string ROM_FILE = "rom.hex";

    // Bus command codes, as sent with i_bus_is_data low
    typedef enum logic [NIBBLE_W-1:0] {
        CMD_PC_READ   = 4'h0,
        CMD_PC_WRITE  = 4'h1,
        CMD_DP_READ   = 4'h2,
        CMD_DP_WRITE  = 4'h3,
        CMD_LOAD_PC   = 4'h4,
        CMD_LOAD_DP   = 4'h5,
        CMD_CONFIGURE = 4'h6,
        CMD_RESET     = 4'hF
    } bus_cmd_t;

    typedef logic [PTR_W-1:0] ptr_t;

endpackage

`default_nettype wire

// File: saturn_bus_slave_top.sv
// Saturn nibble bus memory slave, controller plus pointers plus windowed memory
`timescale 1ns/1ps
`default_nettype none

module saturn_bus_slave_top (
    input  wire logic                                i_clk,
    input  wire logic                                i_reset,
    input  wire logic                                i_bus_clk_en,
    input  wire logic                                i_bus_is_data,
    input  wire logic [saturn_bus_pkg::NIBBLE_W-1:0] i_bus_nibble_in,
    output logic [saturn_bus_pkg::NIBBLE_W-1:0]      o_bus_nibble_out
);
    import saturn_bus_pkg::*;

    ptr_t mem_addr;              // PC or DP, chosen by the controller

    bus_ctrl_if u_ctrl_if ();

    bus_cmd_ctrl u_cmd_ctrl (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_bus_clk_en    (i_bus_clk_en),
        .i_bus_is_data   (i_bus_is_data),
        .i_bus_nibble_in (i_bus_nibble_in),
        .o_ctrl          (u_ctrl_if.ctrl)
    );

    bus_pointer_regs u_pointers (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_ctrl  (u_ctrl_if.ptr),
        .o_addr  (mem_addr)
    );

    nibble_memory u_memory (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_ctrl           (u_ctrl_if.mem),
        .i_addr           (mem_addr),
        .o_bus_nibble_out (o_bus_nibble_out)
    );

endmodule

`default_nettype wire

// File: tb_saturn_bus_slave.sv
// Testbench for the Saturn bus memory slave, random bus traffic checked against a model
`timescale 1ns/1ps
`default_nettype none

module tb_saturn_bus_slave;
    import saturn_bus_pkg::*;

    localparam int HALF_PERIOD  = 50;       // 100 ns clock
    localparam int DRIVE_DELAY  = 5;
    localparam int RESET_CYCLES = 16;
    localparam int N_TRANSFERS  = 2000;
    localparam int MAX_CYCLES   = N_TRANSFERS * 5;  // Up to 4 cycles per transfer plus margin
    localparam int SEED         = 31633;

    logic                i_clk;
    logic                i_reset;
    logic                i_bus_clk_en;
    logic                i_bus_is_data;
    logic [NIBBLE_W-1:0] i_bus_nibble_in;
    logic [NIBBLE_W-1:0] o_bus_nibble_out;

    // Reference model state
    logic [3:0] m_rom [32];
    logic [3:0] m_ram [32];
    logic [3:0] m_cmd;
    int         m_pos;
    ptr_t       m_pc;
    ptr_t       m_dp;
    logic [3:0] m_out;

    int         error_count;
    int         cycle_count;
    int         transfers;
    int         kind;
    int         count;
    int         seed_val;
    ptr_t       addr;

    saturn_bus_slave_top dut (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_bus_clk_en     (i_bus_clk_en),
        .i_bus_is_data    (i_bus_is_data),
        .i_bus_nibble_in  (i_bus_nibble_in),
        .o_bus_nibble_out (o_bus_nibble_out)
    );

    initial begin
        i_clk = 1'b0;
        forever #HALF_PERIOD i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not end within %0d clock cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [3:0] actual,
                               input logic [3:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t: %s = %h, expected %h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Window is address modulo 64, upper half of the window is RAM
    function automatic logic [3:0] model_fetch(input ptr_t a);
        int w;
        w = a % 64;
        if (w >= 32) begin
            return m_ram[w - 32];
        end
        return m_rom[w];
    endfunction

    task automatic model_store(input ptr_t a, input logic [3:0] nib);
        int w;
        w = a % 64;
        if (w >= 32) begin
            m_ram[w - 32] = nib;                 // ROM half keeps its contents
        end
    endtask

    task automatic model_command(input logic [3:0] nib);
        if (nib == CMD_RESET) begin
            m_cmd = CMD_PC_READ;
            m_pc  = '0;
            m_dp  = '0;
        end else begin
            m_cmd = nib;
            if (nib == CMD_LOAD_PC || nib == CMD_LOAD_DP) begin
                m_pos = 0;
            end
        end
    endtask

    task automatic model_data(input logic [3:0] nib);
        case (m_cmd)
            CMD_PC_READ: begin
                m_out = model_fetch(m_pc);
                m_pc  = m_pc + 1;
            end
            CMD_DP_READ: begin
                m_out = model_fetch(m_dp);
                m_dp  = m_dp + 1;
            end
            CMD_PC_WRITE: begin
                model_store(m_pc, nib);
                m_pc = m_pc + 1;
            end
            CMD_DP_WRITE: begin
                model_store(m_dp, nib);
                m_dp = m_dp + 1;
            end
            CMD_LOAD_PC, CMD_LOAD_DP: begin
                if (m_cmd == CMD_LOAD_PC) begin
                    m_pc[m_pos*4 +: 4] = nib;
                end else begin
                    m_dp[m_pos*4 +: 4] = nib;
                end
                if (m_pos == 4) begin
                    m_pos = 0;
                    m_cmd = (m_cmd == CMD_LOAD_PC) ? CMD_PC_READ : CMD_DP_READ;
                end else begin
                    m_pos++;
                end
            end
            default: ;                           // Unhandled commands do nothing
        endcase
    endtask

    // One bus transfer, then a check and 0 to 3 idle cycles
    task automatic send_strobe(input logic is_data, input logic [3:0] nib);
        int idle;
        i_bus_clk_en    = 1'b1;
        i_bus_is_data   = is_data;
        i_bus_nibble_in = nib;
        @(posedge i_clk);
        #DRIVE_DELAY;
        i_bus_clk_en    = 1'b0;
        i_bus_nibble_in = 4'($urandom);          // Bus noise while idle
        if (is_data) begin
            model_data(nib);
        end else begin
            model_command(nib);
        end
        check_value("o_bus_nibble_out", o_bus_nibble_out, m_out);
        transfers++;
        idle = $urandom_range(3, 0);
        repeat (idle) begin
            @(posedge i_clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic send_random_data(input int n);
        repeat (n) send_strobe(1'b1, 4'($urandom));
    endtask

    task automatic load_pointer(input logic is_dp, input ptr_t a);
        send_strobe(1'b0, is_dp ? CMD_LOAD_DP : CMD_LOAD_PC);
        for (int i = 0; i < 5; i++) begin
            send_strobe(1'b1, a[i*4 +: 4]);      // Low nibble first
        end
    endtask

    initial begin
        seed_val        = $urandom(SEED);
        error_count     = 0;
        cycle_count     = 0;
        transfers       = 0;
        i_reset         = 1'b1;
        i_bus_clk_en    = 1'b0;
        i_bus_is_data   = 1'b0;
        i_bus_nibble_in = '0;
        m_cmd = CMD_PC_READ;
        m_pos = 0;
        m_pc  = '0;
        m_dp  = '0;
        m_out = '0;
        $readmemh(ROM_FILE, m_rom);

        repeat (RESET_CYCLES) @(posedge i_clk);
        #DRIVE_DELAY;
        i_reset = 1'b0;
        check_value("o_bus_nibble_out", o_bus_nibble_out, 4'h0);

        send_strobe(1'b1, 4'h0);                 // PC_READ straight after reset, ROM nibble 0

        // Fill the whole RAM half so every later read is known
        load_pointer(1'b1, 20'h00020);
        send_strobe(1'b0, CMD_DP_WRITE);
        send_random_data(32);

        // RESET command puts both pointers back to 0
        send_strobe(1'b0, CMD_RESET);
        send_random_data(2);
        send_strobe(1'b0, CMD_DP_READ);
        send_random_data(2);

        // CONFIGURE is accepted and ignored
        send_strobe(1'b0, CMD_CONFIGURE);
        send_random_data(3);
        send_strobe(1'b0, CMD_PC_READ);
        send_random_data(2);

        while (transfers < N_TRANSFERS) begin
            kind  = $urandom_range(5, 0);
            count = $urandom_range(8, 1);
            addr  = ptr_t'($urandom);
            case (kind)
                0: begin
                    load_pointer(1'($urandom), addr);
                    send_random_data(count);     // Auto switch to read
                end
                1: begin
                    send_strobe(1'b0, $urandom_range(1, 0) ? CMD_DP_WRITE : CMD_PC_WRITE);
                    send_random_data(count);
                end
                2: begin
                    send_strobe(1'b0, $urandom_range(1, 0) ? CMD_DP_READ : CMD_PC_READ);
                    send_random_data(count);
                end
                3: begin
                    // Write through DP, reload the same address, read back
                    load_pointer(1'b1, addr);
                    send_strobe(1'b0, CMD_DP_WRITE);
                    send_random_data(count);
                    load_pointer(1'b1, addr);
                    send_random_data(count);
                end
                4: begin
                    send_strobe(1'b0, CMD_RESET);
                    send_random_data($urandom_range(3, 1));
                end
                default: begin
                    if ($urandom_range(1, 0) == 1) begin
                        send_strobe(1'b0, 4'($urandom_range(14, 6)));
                        send_random_data($urandom_range(3, 1));
                    end else begin
                        // Load cut short by the next command
                        send_strobe(1'b0, $urandom_range(1, 0) ? CMD_LOAD_DP : CMD_LOAD_PC);
                        send_random_data($urandom_range(4, 1));
                    end
                end
            endcase
        end

        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
